/* src.f */
design/rv_pkg.sv
design/reg_file.sv
design/instr_decoder.sv
design/hazard_unit.sv
design/id_ex_stage.sv
design/ex_stage.sv
design/decode_execute_top.sv
bench/tb_decode_execute.sv

/* bench/tb_decode_execute.sv */
`timescale 1ns/1ps

module tb_decode_execute;
  import rv_pkg::*;

  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] store_data;
    logic [4:0]      rd;
    logic            write_en;
    logic            is_load;
    logic            is_store;
    logic            redirect;
    logic [XLEN-1:0] target;
    logic [XLEN-1:0] load_val;
  } exp_t;

  logic                  clk;
  logic                  rst_n_i;
  logic [XLEN-1:0]       if_pc_i;
  logic [31:0]           if_instr_i;
  logic                  if_valid_i;
  logic                  wb_we_i;
  logic [REG_ADDR_W-1:0] wb_rd_i;
  logic [XLEN-1:0]       wb_data_i;
  ex_mem_t               ex_mem_o;
  logic                  stall_o;
  logic                  redirect_o;
  logic [XLEN-1:0]       redirect_pc_o;

  logic [XLEN-1:0] mregs [0:31];  // Architectural registers in program order.
  logic [31:0]     prog [$];
  int              test_start [2:6];
  exp_t            exp1;  // Entry expected in ID/EX.
  exp_t            exp2;  // Entry expected on ex_mem_o.
  logic [XLEN-1:0] pc;
  int              cur_test;
  int              err_cnt;
  int              failed_tests;
  bit              built;

  decode_execute_top #(.XLEN(XLEN)) u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .if_pc_i       (if_pc_i),
    .if_instr_i    (if_instr_i),
    .if_valid_i    (if_valid_i),
    .wb_we_i       (wb_we_i),
    .wb_rd_i       (wb_rd_i),
    .wb_data_i     (wb_data_i),
    .ex_mem_o      (ex_mem_o),
    .stall_o       (stall_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [4:0] pick_reg(input int lo, input int hi);
    return 5'(lo + $urandom % (hi - lo + 1));
  endfunction

  // Register-register or immediate ALU op, or lui/auipc.
  function automatic logic [31:0] random_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'($urandom);
    alt = 1'($urandom);
    imm = 12'($urandom);
    case ($urandom % 4)
      0: return r_type({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0}, rs2, rs1, f3, rd);
      1: begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          imm = {1'b0, alt && (f3 == 3'd5), 5'b0, imm[4:0]};  // Shift amount form.
        end
        return i_type(imm, rs1, f3, rd, OPC_OPIMM);
      end
      2: return u_type(20'($urandom), rd, OPC_LUI);
      default: return u_type(20'($urandom), rd, OPC_AUIPC);
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Executes one instruction on the architectural model.
  task automatic execute_model(input logic [31:0] ins, input logic [XLEN-1:0] ipc,
                               output exp_t e);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_u;
    a          = mregs[ins[19:15]];
    b          = mregs[ins[24:20]];
    imm_i      = {{20{ins[31]}}, ins[31:20]};
    imm_s      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b      = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j      = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    imm_u      = {ins[31:12], 12'b0};
    e          = '0;
    e.valid    = 1'b1;
    e.rd       = ins[11:7];
    e.write_en = 1'b1;
    case (ins[6:0])
      OPC_LUI:   e.result = imm_u;
      OPC_AUIPC: e.result = ipc + imm_u;
      7'b1101111: begin
        e.result   = ipc + 32'd4;
        e.redirect = 1'b1;
        e.target   = ipc + imm_j;
      end
      OPC_JALR: begin
        e.result   = ipc + 32'd4;
        e.redirect = 1'b1;
        e.target   = (a + imm_i) & ~32'd1;
      end
      7'b1100011: begin
        e.write_en = 1'b0;
        e.redirect = branch_taken(ins[14:12], a, b);
        e.target   = ipc + imm_b;
      end
      OPC_LOAD: begin
        e.result   = a + imm_i;
        e.is_load  = 1'b1;
        e.load_val = $urandom;
      end
      7'b0100011: begin
        e.write_en   = 1'b0;
        e.is_store   = 1'b1;
        e.result     = a + imm_s;
        e.store_data = b;
      end
      OPC_OPIMM: e.result = alu_ref(ins[14:12], ins[30] && (ins[14:12] == 3'd5), a, imm_i);
      7'b0110011: e.result = alu_ref(ins[14:12], ins[30], a, b);
      default: e.write_en = 1'b0;
    endcase
    if (e.write_en && (e.rd != 5'd0)) begin
      mregs[e.rd] = e.is_load ? e.load_val : e.result;
    end
  endtask

  // Presents one fetch slot and follows the DUT's stall and redirect like a fetch unit.
  task automatic issue_slot(input logic valid, input logic [31:0] ins, output bit consumed);
    exp_t e;
    if_valid_i <= valid;
    if_instr_i <= ins;
    if_pc_i    <= pc;
    @(posedge clk);
    consumed = 1'b0;
    e        = '0;
    if (redirect_o) begin
      pc       = exp1.target;  // The slot on the wrong path is squashed.
      consumed = valid;
    end else if (valid && !stall_o) begin
      execute_model(ins, pc, e);
      pc       = pc + 32'd4;
      consumed = 1'b1;
    end
    exp1 <= e;
  endtask

  task automatic run_test(input int num, input string name, input int first, input int last);
    int idx;
    int errs_before;
    bit consumed;
    cur_test    = num;
    errs_before = err_cnt;
    idx         = first;
    while (idx < last) begin
      issue_slot(1'b1, prog[idx], consumed);
      if (consumed) idx++;
    end
    repeat (4) issue_slot(1'b0, 32'h0, consumed);  // Drain EX/MEM and writeback.
    if (err_cnt != errs_before) failed_tests++;
    $display("[test %0d] %s: %0d instructions, %0d errors", num, name, last - first,
             err_cnt - errs_before);
  endtask

  task automatic build_programs();
    int          lo;
    logic [4:0]  rd;
    logic [4:0]  prev1;
    logic [4:0]  prev2;
    logic [2:0]  br_f3 [6];
    logic [31:0] shadow;
    br_f3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    shadow = i_type(12'd1, 5'd7, 3'd0, 5'd7, OPC_OPIMM);
    // Each bank of seven registers is touched only every fourth slot.
    test_start[2] = prog.size();
    for (int i = 0; i < 24; i++) begin
      lo = 1 + (i % 4) * 7;
      prog.push_back(random_alu(pick_reg(lo, lo + 6), pick_reg(lo, lo + 6),
                                pick_reg(lo, lo + 6)));
    end
    test_start[3] = prog.size();
    prev1 = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 24; i++) begin
      rd = pick_reg(1, 31);
      prog.push_back(random_alu(rd, prev1, prev2));
      prev2 = prev1;
      prev1 = rd;
    end
    test_start[4] = prog.size();
    for (int g = 0; g < 8; g++) begin
      rd = pick_reg(1, 10);
      prog.push_back(i_type(12'($urandom), pick_reg(11, 20), 3'd2, rd, OPC_LOAD));
      if (g % 4 == 3) prog.push_back(i_type(12'd8, rd, 3'd2, pick_reg(1, 10), OPC_LOAD));
      if (g % 2 == 1) prog.push_back(i_type(12'd1, pick_reg(11, 20), 3'd0, 5'd21, OPC_OPIMM));
      prog.push_back(r_type(7'b0, pick_reg(22, 31), rd, 3'd0, pick_reg(22, 31)));
    end
    test_start[5] = prog.size();
    prog.push_back(i_type(12'd5, 5'd0, 3'd0, 5'd1, OPC_OPIMM));
    prog.push_back(i_type(12'd5, 5'd0, 3'd0, 5'd2, OPC_OPIMM));
    prog.push_back(i_type(12'hffd, 5'd0, 3'd0, 5'd3, OPC_OPIMM));
    for (int i = 0; i < 10; i++) begin
      prog.push_back(b_type(13'(4 * (1 + $urandom % 8)), pick_reg(1, 3), pick_reg(1, 3),
                            br_f3[$urandom % 6]));
      prog.push_back(shadow);
    end
    prog.push_back(j_type(21'd24, 5'd4));
    prog.push_back(shadow);
    prog.push_back(i_type(12'd8, 5'd4, 3'd0, 5'd5, OPC_JALR));
    prog.push_back(shadow);
    prog.push_back(j_type(21'h1ffff0, 5'd8));  // Backward jump.
    prog.push_back(shadow);
    prog.push_back(r_type(7'b0, 5'd5, 5'd4, 3'd0, 5'd6));
    test_start[6] = prog.size();
    for (int i = 0; i < 6; i++) begin
      prog.push_back(s_type(12'($urandom), pick_reg(1, 31), pick_reg(1, 31), 3'd2));
    end
    prog.push_back(i_type(12'h123, 5'd0, 3'd0, 5'd12, OPC_OPIMM));
    prog.push_back(s_type(12'd0, 5'd12, 5'd1, 3'd2));  // Store data comes from EX/MEM.
    prog.push_back(i_type(12'd77, 5'd1, 3'd0, 5'd0, OPC_OPIMM));
    prog.push_back(u_type(20'habcde, 5'd0, OPC_LUI));
    prog.push_back(r_type(7'b0, 5'd0, 5'd0, 3'd0, 5'd9));
    prog.push_back(s_type(12'd4, 5'd0, 5'd1, 3'd2));
    prog.push_back(r_type(7'b0, 5'd1, 5'd0, 3'd0, 5'd10));
  endtask

  task automatic log_failure(input string line);
    err_cnt++;
    $display("%s", line);
  endtask

  // Writeback stage, one cycle behind EX/MEM.
  always @(posedge clk) begin
    wb_we_i   <= ex_mem_o.valid && ex_mem_o.write_en;
    wb_rd_i   <= ex_mem_o.rd;
    wb_data_i <= ex_mem_o.is_load ? exp2.load_val : ex_mem_o.result;
  end

  always @(posedge clk) begin
    exp2 <= exp1;
  end

  assert property (@(posedge clk) $rose(rst_n_i) |-> (!ex_mem_o.valid && !stall_o && !redirect_o))
    else log_failure("Outputs were not idle after reset.");

  assert property (@(posedge clk) disable iff (!rst_n_i) ex_mem_o.valid == exp2.valid)
    else log_failure($sformatf("[ERROR] ex_mem_o.valid expected %h got %h",
                               $sampled(exp2.valid), $sampled(ex_mem_o.valid)));

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (exp2.valid && (exp2.write_en || exp2.is_store)) |-> (ex_mem_o.result == exp2.result))
    else log_failure($sformatf("[ERROR] ex_mem_o.result expected %h got %h",
                               $sampled(exp2.result), $sampled(ex_mem_o.result)));

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (exp2.valid && exp2.write_en) |-> (ex_mem_o.rd == exp2.rd))
    else log_failure($sformatf("[ERROR] ex_mem_o.rd expected %h got %h",
                               $sampled(exp2.rd), $sampled(ex_mem_o.rd)));

  assert property (@(posedge clk) disable iff (!rst_n_i) exp2.valid |->
    ({ex_mem_o.write_en, ex_mem_o.is_load, ex_mem_o.is_store} ==
     {exp2.write_en, exp2.is_load, exp2.is_store}))
    else log_failure($sformatf("[ERROR] ex_mem_o.{write_en,is_load,is_store} expected %h got %h",
      $sampled({exp2.write_en, exp2.is_load, exp2.is_store}),
      $sampled({ex_mem_o.write_en, ex_mem_o.is_load, ex_mem_o.is_store})));

  assert property (@(posedge clk) disable iff (!rst_n_i)
    (exp2.valid && exp2.is_store) |-> (ex_mem_o.store_data == exp2.store_data))
    else log_failure($sformatf("[ERROR] ex_mem_o.store_data expected %h got %h",
                               $sampled(exp2.store_data), $sampled(ex_mem_o.store_data)));

  assert property (@(posedge clk) disable iff (!rst_n_i) redirect_o == exp1.redirect)
    else log_failure($sformatf("[ERROR] redirect_o expected %h got %h",
                               $sampled(exp1.redirect), $sampled(redirect_o)));

  assert property (@(posedge clk) disable iff (!rst_n_i)
    exp1.redirect |-> (redirect_pc_o == exp1.target))
    else log_failure($sformatf("[ERROR] redirect_pc_o expected %h got %h",
                               $sampled(exp1.target), $sampled(redirect_pc_o)));

  assert property (@(posedge clk) disable iff (!rst_n_i) (stall_o ##1 stall_o) |=> !stall_o)
    else log_failure("Stall lasted longer than two cycles.");

  assert property (@(posedge clk) disable iff (!rst_n_i) (cur_test == 3) |-> !stall_o)
    else log_failure("Stall raised during a sequence that forwarding alone should cover.");

  initial begin
    wait (built);
    repeat (prog.size() * 4 + 100) @(posedge clk);
    $display("Watchdog expired before the test programs finished.");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n_i      = 1'b0;
    if_valid_i   = 1'b0;
    if_instr_i   = '0;
    if_pc_i      = '0;
    wb_we_i      = 1'b0;
    wb_rd_i      = '0;
    wb_data_i    = '0;
    exp1         = '0;
    exp2         = '0;
    pc           = 32'h0000_0100;
    err_cnt      = 0;
    failed_tests = 0;
    cur_test     = 0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    void'($urandom(32'h88a3));
    build_programs();
    built = 1'b1;
    repeat (2) @(posedge clk);
    rst_n_i <= 1'b1;
    @(posedge clk);
    run_test(1, "reset", 0, 0);
    run_test(2, "independent ALU ops", test_start[2], test_start[3]);
    run_test(3, "back-to-back dependencies", test_start[3], test_start[4]);
    run_test(4, "load followed by use", test_start[4], test_start[5]);
    run_test(5, "branches and jumps", test_start[5], test_start[6]);
    run_test(6, "stores and x0", test_start[6], prog.size());
    $display("Tests run: 6, tests with errors: %0d, failed checks: %0d", failed_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* design/decode_execute_top.sv */
`timescale 1ns/1ps

module decode_execute_top #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [XLEN-1:0]               if_pc_i,
  input  logic [31:0]                   if_instr_i,
  input  logic                          if_valid_i,
  input  logic                          wb_we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
  input  logic [XLEN-1:0]               wb_data_i,
  output rv_pkg::ex_mem_t               ex_mem_o,
  output logic                          stall_o,
  output logic                          redirect_o,
  output logic [XLEN-1:0]               redirect_pc_o
);
  import rv_pkg::*;

  id_ex_t                dec;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  id_ex_t                idex;
  logic                  idex_valid;
  logic [XLEN-1:0]       op_a;
  logic [XLEN-1:0]       op_b;
  logic                  fwd_wb_a;
  logic                  fwd_wb_b;
  fwd_sel_e              fwd_ex_a;
  fwd_sel_e              fwd_ex_b;
  logic                  load_stall;
  logic                  clear;

  assign clear   = load_stall || redirect_o || !if_valid_i;
  assign stall_o = load_stall && !redirect_o;  // A squashed instruction need not be held.

  instr_decoder #(.XLEN(XLEN)) u_decoder (
    .pc_i       (if_pc_i),
    .instr_i    (if_instr_i),
    .dec_o      (dec),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr)
  );

  reg_file #(.XLEN(XLEN)) u_reg_file (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .we_i       (wb_we_i),
    .rd_addr_i  (wb_rd_i),
    .rd_data_i  (wb_data_i),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  hazard_unit u_hazard (
    .dec_rs1_i    (rs1_addr),
    .dec_rs2_i    (rs2_addr),
    .idex_i       (idex),
    .idex_valid_i (idex_valid),
    .exmem_i      (ex_mem_o),
    .wb_we_i      (wb_we_i),
    .wb_rd_i      (wb_rd_i),
    .fwd_wb_a_o   (fwd_wb_a),
    .fwd_wb_b_o   (fwd_wb_b),
    .fwd_ex_a_o   (fwd_ex_a),
    .fwd_ex_b_o   (fwd_ex_b),
    .load_stall_o (load_stall)
  );

  id_ex_stage #(.XLEN(XLEN)) u_id_ex (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear),
    .dec_i        (dec),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .wb_data_i    (wb_data_i),
    .fwd_wb_a_i   (fwd_wb_a),
    .fwd_wb_b_i   (fwd_wb_b),
    .fwd_ex_a_i   (fwd_ex_a),
    .fwd_ex_b_i   (fwd_ex_b),
    .ex_result_i  (ex_mem_o.result),
    .idex_o       (idex),
    .idex_valid_o (idex_valid),
    .op_a_o       (op_a),
    .op_b_o       (op_b)
  );

  ex_stage #(.XLEN(XLEN)) u_ex (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .idex_i        (idex),
    .idex_valid_i  (idex_valid),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .exmem_o       (ex_mem_o),
    .redirect_o    (redirect_o),
    .redirect_pc_o (redirect_pc_o)
  );

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  rv_pkg::id_ex_t  idex_i,
  input  logic            idex_valid_i,
  input  logic [XLEN-1:0] op_a_i,
  input  logic [XLEN-1:0] op_b_i,
  output rv_pkg::ex_mem_t exmem_o,
  output logic            redirect_o,
  output logic [XLEN-1:0] redirect_pc_o
);
  import rv_pkg::*;

  logic [XLEN-1:0]         alu_a;
  logic [XLEN-1:0]         alu_b;
  logic [XLEN-1:0]         alu_out;
  logic [$clog2(XLEN)-1:0] shamt;
  logic                    taken;
  logic                    is_jalr;
  logic [XLEN-1:0]         target;
  logic [XLEN-1:0]         ex_result;

  assign alu_a = idex_i.ctrl.auipc ? idex_i.pc : op_a_i;
  assign alu_b = idex_i.ctrl.imm_sel ? idex_i.imm : op_b_i;
  assign shamt = alu_b[$clog2(XLEN)-1:0];

  always_comb begin
    case (idex_i.ctrl.alu_op)
      ALU_ADD:    alu_out = alu_a + alu_b;
      ALU_SUB:    alu_out = alu_a - alu_b;
      ALU_SLL:    alu_out = alu_a << shamt;
      ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:    alu_out = alu_a ^ alu_b;
      ALU_SRL:    alu_out = alu_a >> shamt;
      ALU_SRA:    alu_out = $signed(alu_a) >>> shamt;
      ALU_OR:     alu_out = alu_a | alu_b;
      ALU_AND:    alu_out = alu_a & alu_b;
      ALU_PASS_B: alu_out = alu_b;
      default:    alu_out = '0;
    endcase
  end

  always_comb begin
    case (idex_i.ctrl.br_cond)
      BR_EQ:   taken = (op_a_i == op_b_i);
      BR_NE:   taken = (op_a_i != op_b_i);
      BR_LT:   taken = ($signed(op_a_i) < $signed(op_b_i));
      BR_GE:   taken = ($signed(op_a_i) >= $signed(op_b_i));
      BR_LTU:  taken = (op_a_i < op_b_i);
      BR_GEU:  taken = (op_a_i >= op_b_i);
      default: taken = 1'b0;
    endcase
  end

  // Jalr is the only jump that takes its immediate as operand B.
  assign is_jalr   = idex_i.ctrl.jump && idex_i.ctrl.imm_sel;
  assign target    = (is_jalr ? op_a_i : idex_i.pc) + idex_i.imm;
  assign ex_result = idex_i.ctrl.jump ? idex_i.pc + XLEN'(4) : alu_out;  // Link address.

  assign redirect_o    = idex_valid_i && (idex_i.ctrl.jump || (idex_i.ctrl.branch && taken));
  assign redirect_pc_o = is_jalr ? {target[XLEN-1:1], 1'b0} : target;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exmem_o <= '0;
    end else begin
      exmem_o.valid      <= idex_valid_i;
      exmem_o.result     <= ex_result;
      exmem_o.store_data <= op_b_i;
      exmem_o.rd         <= idex_i.rd;
      exmem_o.write_en   <= idex_valid_i && idex_i.ctrl.write_en;
      exmem_o.is_load    <= idex_valid_i && idex_i.ctrl.is_load;
      exmem_o.is_store   <= idex_valid_i && idex_i.ctrl.is_store;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(redirect_o) |-> idex_valid_i)
    else $error("[ERROR] ex_stage: redirect raised by a bubble");

  // The squash at the top turns the next ID/EX entry into a bubble.
  assert property (@(posedge clk) disable iff (!rst_n_i)
    redirect_o |=> !redirect_o)
    else $error("[ERROR] ex_stage: redirect held for more than one cycle");

endmodule

/* design/id_ex_stage.sv */
`timescale 1ns/1ps

module id_ex_stage #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             clear_i,
  input  rv_pkg::id_ex_t   dec_i,
  input  logic [XLEN-1:0]  rs1_data_i,
  input  logic [XLEN-1:0]  rs2_data_i,
  input  logic [XLEN-1:0]  wb_data_i,
  input  logic             fwd_wb_a_i,
  input  logic             fwd_wb_b_i,
  input  rv_pkg::fwd_sel_e fwd_ex_a_i,
  input  rv_pkg::fwd_sel_e fwd_ex_b_i,
  input  logic [XLEN-1:0]  ex_result_i,
  output rv_pkg::id_ex_t   idex_o,
  output logic             idex_valid_o,
  output logic [XLEN-1:0]  op_a_o,
  output logic [XLEN-1:0]  op_b_o
);
  import rv_pkg::*;

  logic [XLEN-1:0] op_a_q;
  logic [XLEN-1:0] op_b_q;

  function automatic logic [XLEN-1:0] ex_fwd(
    input fwd_sel_e        sel,
    input logic [XLEN-1:0] held,
    input logic [XLEN-1:0] ex_val,
    input logic [XLEN-1:0] wb_val
  );
    case (sel)
      FWD_EXMEM: return ex_val;
      FWD_WB:    return wb_val;
      default:   return held;
    endcase
  endfunction

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idex_o       <= '0;
      idex_valid_o <= 1'b0;
    end else begin
      idex_o       <= dec_i;
      idex_valid_o <= !clear_i;
      if (clear_i) begin  // A stall or squash leaves a bubble behind.
        idex_o.ctrl.write_en <= 1'b0;
        idex_o.ctrl.is_store <= 1'b0;
      end
    end
  end

  // Writeback data overrides a stale register-file read.
  always_ff @(posedge clk) begin
    op_a_q <= fwd_wb_a_i ? wb_data_i : rs1_data_i;
    op_b_q <= fwd_wb_b_i ? wb_data_i : rs2_data_i;
  end

  assign op_a_o = ex_fwd(fwd_ex_a_i, op_a_q, ex_result_i, wb_data_i);
  assign op_b_o = ex_fwd(fwd_ex_b_i, op_b_q, ex_result_i, wb_data_i);

  assert property (@(posedge clk) disable iff (!rst_n_i)
    clear_i |=> (!idex_valid_o && !idex_o.ctrl.write_en && !idex_o.ctrl.is_store))
    else $error("[ERROR] id_ex_stage: bubble after clear still writes or stores");

endmodule

/* design/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rs1_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] dec_rs2_i,
  input  rv_pkg::id_ex_t                idex_i,
  input  logic                          idex_valid_i,
  input  rv_pkg::ex_mem_t               exmem_i,
  input  logic                          wb_we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
  output logic                          fwd_wb_a_o,
  output logic                          fwd_wb_b_o,
  output rv_pkg::fwd_sel_e              fwd_ex_a_o,
  output rv_pkg::fwd_sel_e              fwd_ex_b_o,
  output logic                          load_stall_o
);
  import rv_pkg::*;

  logic wb_live;
  logic ex_live;
  logic idex_load;
  logic exmem_load;

  // Producers with rd equal to x0 are dropped here, so sources need no x0 test.
  assign wb_live   = wb_we_i && (wb_rd_i != '0);
  assign ex_live   = exmem_i.valid && exmem_i.write_en && !exmem_i.is_load
                     && (exmem_i.rd != '0);
  assign idex_load = idex_valid_i && idex_i.ctrl.is_load && idex_i.ctrl.write_en
                     && (idex_i.rd != '0);
  assign exmem_load = exmem_i.valid && exmem_i.is_load && exmem_i.write_en
                      && (exmem_i.rd != '0) && !(wb_live && (wb_rd_i == exmem_i.rd));

  assign fwd_wb_a_o = wb_live && (wb_rd_i == dec_rs1_i);
  assign fwd_wb_b_o = wb_live && (wb_rd_i == dec_rs2_i);

  // The EX/MEM result is younger than the writeback, so it wins.
  always_comb begin
    fwd_ex_a_o = FWD_NONE;
    fwd_ex_b_o = FWD_NONE;
    if (ex_live && (exmem_i.rd == idex_i.rs1)) fwd_ex_a_o = FWD_EXMEM;
    else if (wb_live && (wb_rd_i == idex_i.rs1)) fwd_ex_a_o = FWD_WB;
    if (ex_live && (exmem_i.rd == idex_i.rs2)) fwd_ex_b_o = FWD_EXMEM;
    else if (wb_live && (wb_rd_i == idex_i.rs2)) fwd_ex_b_o = FWD_WB;
  end

  assign load_stall_o =
    (idex_load && ((idex_i.rd == dec_rs1_i) || (idex_i.rd == dec_rs2_i))) ||
    (exmem_load && ((exmem_i.rd == dec_rs1_i) || (exmem_i.rd == dec_rs2_i)));

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic [XLEN-1:0]               pc_i,
  input  logic [31:0]                   instr_i,
  output rv_pkg::id_ex_t                dec_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o
);
  import rv_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  alu_op_e         arith_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  assign imm_i = {{(XLEN-11){instr_i[31]}}, instr_i[30:20]};
  assign imm_s = {{(XLEN-11){instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
  assign imm_b = {{(XLEN-12){instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {{(XLEN-31){instr_i[31]}}, instr_i[30:12], 12'b0};
  assign imm_j = {{(XLEN-20){instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // Bit 30 picks sub over add only for register-register ops.
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && instr_i[30]) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = instr_i[30] ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    dec_o              = '0;  // Unknown opcodes stay a harmless no-op.
    dec_o.pc           = pc_i;
    dec_o.rd           = instr_i[11:7];
    dec_o.ctrl.alu_op  = ALU_ADD;
    dec_o.ctrl.br_cond = br_cond_e'(funct3);
    case (opcode)
      OPC_LUI: begin
        dec_o.imm = imm_u;
        dec_o.ctrl.imm_sel = 1'b1;
        dec_o.ctrl.write_en = 1'b1;
        dec_o.ctrl.alu_op = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        dec_o.imm = imm_u;
        dec_o.ctrl.imm_sel = 1'b1;
        dec_o.ctrl.auipc = 1'b1;
        dec_o.ctrl.write_en = 1'b1;
      end
      OPC_JAL: begin
        dec_o.imm = imm_j;
        dec_o.ctrl.jump = 1'b1;
        dec_o.ctrl.write_en = 1'b1;
      end
      OPC_JALR: begin
        dec_o.imm = imm_i;
        dec_o.rs1 = instr_i[19:15];
        dec_o.ctrl.imm_sel = 1'b1;  // Marks the rs1-relative target.
        dec_o.ctrl.jump = 1'b1;
        dec_o.ctrl.write_en = 1'b1;
      end
      OPC_BRANCH: begin
        dec_o.imm = imm_b;
        dec_o.rs1 = instr_i[19:15];
        dec_o.rs2 = instr_i[24:20];
        dec_o.ctrl.branch = 1'b1;
        dec_o.ctrl.alu_op = ALU_SUB;
      end
      OPC_LOAD: begin
        dec_o.imm = imm_i;
        dec_o.rs1 = instr_i[19:15];
        dec_o.ctrl.imm_sel = 1'b1;
        dec_o.ctrl.is_load = 1'b1;
        dec_o.ctrl.write_en = 1'b1;
      end
      OPC_STORE: begin
        dec_o.imm = imm_s;
        dec_o.rs1 = instr_i[19:15];
        dec_o.rs2 = instr_i[24:20];
        dec_o.ctrl.imm_sel = 1'b1;
        dec_o.ctrl.is_store = 1'b1;
      end
      OPC_OPIMM: begin
        dec_o.imm = imm_i;
        dec_o.rs1 = instr_i[19:15];
        dec_o.ctrl.imm_sel = 1'b1;
        dec_o.ctrl.write_en = 1'b1;
        dec_o.ctrl.alu_op = arith_op;
      end
      OPC_OP: begin
        dec_o.rs1 = instr_i[19:15];
        dec_o.rs2 = instr_i[24:20];
        dec_o.ctrl.write_en = 1'b1;
        dec_o.ctrl.alu_op = arith_op;
      end
      default: ;
    endcase
  end

  // Unused sources read as x0 so they never raise a false hazard.
  assign rs1_addr_o = dec_o.rs1;
  assign rs2_addr_o = dec_o.rs2;

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
  parameter int XLEN = rv_pkg::XLEN
) (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  logic                          we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic [XLEN-1:0]               rd_data_i,
  output logic [XLEN-1:0]               rs1_data_o,
  output logic [XLEN-1:0]               rs2_data_o
);
  import rv_pkg::*;

  localparam int NREGS = 2 ** REG_ADDR_W;

  logic [XLEN-1:0] regs [1:NREGS-1];  // x0 has no storage.

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_addr_i != '0)) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // A write aimed at x0 must not land in any other register.
  assert property (@(posedge clk) disable iff (!rst_n_i)
    (we_i && (rd_addr_i == '0)) ##1 $stable(rs1_addr_i) |-> $stable(rs1_data_o))
    else $error("[ERROR] reg_file: a write to x0 changed another register");

endmodule

/* design/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // Lui passes the immediate straight through.
  } alu_op_e;

  // Branch encodings are the funct3 values, so decode is a plain cast.
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {
    FWD_NONE,   // Operand as captured at the ID/EX edge.
    FWD_EXMEM,  // Result sitting in EX/MEM.
    FWD_WB      // Data on the writeback port this cycle.
  } fwd_sel_e;

  typedef struct packed {
    logic     write_en;
    logic     imm_sel;   // ALU operand B is the immediate.
    logic     auipc;     // ALU operand A is the PC.
    logic     jump;
    logic     branch;
    logic     is_load;
    logic     is_store;
    alu_op_e  alu_op;
    br_cond_e br_cond;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    ctrl_t                 ctrl;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       result;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] rd;
    logic                  write_en;
    logic                  is_load;
    logic                  is_store;
  } ex_mem_t;

endpackage
